//--- im2col_spc.f
+incdir+source
source/im2col_pkg.sv
source/im2col_param_gen.sv
source/im2col_fifo.sv
source/im2col_ch_tracker.sv
source/im2col_dma_loader.sv
source/im2col_spc.sv
testbench/tb_im2col_spc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the im2col testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_im2col_spc \
  -f im2col_spc.f \
  -o sim_tb

# the simulator exits non-zero on a failed check, the grep below decides
sim_out=$(./obj_dir/sim_tb) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi

//--- source/im2col_ch_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "im2col_defines.svh"

module im2col_ch_tracker (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          alloc_i,
  input  wire [`IM2COL_NUM_CH-1:0]     dma_done_i,
  output logic                         free_o,
  output logic [`IM2COL_CH_W-1:0]      ch_o
);

  logic [`IM2COL_NUM_CH-1:0] busy_q;

  // lowest numbered idle channel wins
  always_comb begin
    ch_o = '0;
    for (int i = `IM2COL_NUM_CH - 1; i >= 0; i--) begin
      if (!busy_q[i]) ch_o = `IM2COL_CH_W'(i);
    end
  end

  assign free_o = ~&busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      for (int i = 0; i < `IM2COL_NUM_CH; i++) begin
        if (dma_done_i[i]) busy_q[i] <= 1'b0;  // channel finished its transfer
      end
      if (alloc_i) busy_q[ch_o] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/im2col_defines.svh
`ifndef IM2COL_DEFINES_SVH
`define IM2COL_DEFINES_SVH

// bus and transaction field widths
`define IM2COL_DATA_W 32
`define IM2COL_ADDR_W 32

// DMA address map, one register window per channel
`define IM2COL_DMA_BASE    32'h0003_0000
`define IM2COL_DMA_CH_SIZE 32'h0000_0100

`define IM2COL_OFS_SRC_PTR    32'h00
`define IM2COL_OFS_DST_PTR    32'h04
`define IM2COL_OFS_SIZE_D1    32'h0C  // writing this one starts the channel
`define IM2COL_OFS_SIZE_D2    32'h10
`define IM2COL_OFS_SRC_INC_D1 32'h18
`define IM2COL_OFS_SRC_INC_D2 32'h1C
`define IM2COL_OFS_DST_INC_D1 32'h20
`define IM2COL_OFS_DST_INC_D2 32'h24
`define IM2COL_OFS_DATA_TYPE  32'h2C
`define IM2COL_OFS_DIM        32'h34
`define IM2COL_OFS_TOP_PAD    32'h3C
`define IM2COL_OFS_BOTTOM_PAD 32'h40
`define IM2COL_OFS_RIGHT_PAD  32'h44
`define IM2COL_OFS_LEFT_PAD   32'h48

`define IM2COL_FIFO_DEPTH 4
`define IM2COL_NUM_CH     2
`define IM2COL_CH_W       1

`endif

//--- source/im2col_dma_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "im2col_defines.svh"

module im2col_dma_loader (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          empty_i,
  input  wire im2col_pkg::dma_trans_t  trans_i,
  output logic                         pop_o,
  input  wire                          free_i,
  input  wire [`IM2COL_CH_W-1:0]       ch_i,
  output logic                         alloc_o,
  output im2col_pkg::bus_req_t         bus_req_o,
  input  wire                          bus_gnt_i,
  output logic                         idle_o
);

  typedef logic [`IM2COL_DATA_W-1:0] word_t;
  typedef logic [`IM2COL_ADDR_W-1:0] addr_t;

  typedef enum logic {
    LD_IDLE, LD_WRITE
  } state_e;

  state_e                 state_q;
  logic [3:0]             idx_q;    // register being written, 0..13
  im2col_pkg::dma_trans_t trans_q;
  logic [`IM2COL_CH_W-1:0] ch_q;
  addr_t                  ofs;
  word_t                  wdata;

  // take a job only when there is a channel to put it on
  assign pop_o   = (state_q == LD_IDLE) && !empty_i && free_i;
  assign alloc_o = pop_o;
  assign idle_o  = (state_q == LD_IDLE);

  always_comb begin
    case (idx_q)
      4'd0:    begin ofs = `IM2COL_OFS_DIM;        wdata = word_t'(1);                 end
      4'd1:    begin ofs = `IM2COL_OFS_DATA_TYPE;  wdata = word_t'(trans_q.data_type); end
      4'd2:    begin ofs = `IM2COL_OFS_TOP_PAD;    wdata = trans_q.n_zeros_top;        end
      4'd3:    begin ofs = `IM2COL_OFS_BOTTOM_PAD; wdata = trans_q.n_zeros_bottom;     end
      4'd4:    begin ofs = `IM2COL_OFS_LEFT_PAD;   wdata = trans_q.n_zeros_left;       end
      4'd5:    begin ofs = `IM2COL_OFS_RIGHT_PAD;  wdata = trans_q.n_zeros_right;      end
      4'd6:    begin ofs = `IM2COL_OFS_SRC_PTR;    wdata = trans_q.input_ptr;          end
      4'd7:    begin ofs = `IM2COL_OFS_DST_PTR;    wdata = trans_q.output_ptr;         end
      4'd8:    begin ofs = `IM2COL_OFS_SRC_INC_D1; wdata = word_t'(1);                 end
      4'd9:    begin ofs = `IM2COL_OFS_SRC_INC_D2; wdata = trans_q.in_inc_d2;          end
      4'd10:   begin ofs = `IM2COL_OFS_DST_INC_D1; wdata = word_t'(1);                 end
      4'd11:   begin ofs = `IM2COL_OFS_DST_INC_D2; wdata = word_t'(1);                 end
      4'd12:   begin ofs = `IM2COL_OFS_SIZE_D2;    wdata = trans_q.size_d2;            end
      default: begin ofs = `IM2COL_OFS_SIZE_D1;    wdata = trans_q.size_d1;            end
    endcase
  end

  // request fields come straight from registers, so they hold until granted
  assign bus_req_o.req   = (state_q == LD_WRITE);
  assign bus_req_o.we    = 1'b1;
  assign bus_req_o.be    = 4'b1111;
  assign bus_req_o.addr  = `IM2COL_DMA_BASE + addr_t'(ch_q) * `IM2COL_DMA_CH_SIZE + ofs;
  assign bus_req_o.wdata = wdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        LD_IDLE: begin
          if (pop_o) begin
            state_q <= LD_WRITE;
            idx_q   <= '0;
          end
        end
        LD_WRITE: begin
          if (bus_gnt_i) begin
            if (idx_q == 4'd13) begin
              state_q <= LD_IDLE;  // size d1 accepted, channel is running
            end else begin
              idx_q <= idx_q + 4'd1;
            end
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      trans_q <= trans_i;
      ch_q    <= ch_i;
    end
  end

endmodule

`default_nettype wire

//--- source/im2col_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module im2col_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned depth     = 4
) (
  input  wire      clk_i,
  input  wire      rst_ni,
  input  wire      push_i,
  input  payload_t data_i,
  input  wire      pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t         mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             do_push, do_pop;

  assign full_o  = (cnt_q == cnt_w'(depth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i && !full_o;  // writes into a full buffer are dropped
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];   // head entry

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

//--- source/im2col_param_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "im2col_defines.svh"

module im2col_param_gen (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          start_i,
  input  wire im2col_pkg::im2col_cfg_t cfg_i,
  input  wire                          full_i,
  output logic                         push_o,
  output im2col_pkg::dma_trans_t       trans_o,
  output logic                         active_o
);

  typedef logic [`IM2COL_DATA_W-1:0] word_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_OFS, ST_COORD, ST_ZEROS, ST_XFER, ST_PUSH
  } state_e;

  state_e                  state_q;
  im2col_pkg::im2col_cfg_t cfg_q;
  logic [7:0]              c_q, kh_q, kw_q;
  word_t                   fw_min_q, fh_min_q;  // filter taps left of the current one
  word_t                   row_q, col_q;
  word_t                   z_top_q, z_bot_q, z_left_q, z_right_q;
  word_t                   sz1_q, sz2_q, in_ptr_q, in_inc_q, out_ptr_q;
  word_t                   rpad_raw, bpad_raw, rpad, bpad, sz1_c, patch_sz;
  logic                    last_c;

  // padding the patch grid needs beyond the image edge
  assign rpad_raw = word_t'(cfg_q.n_patches_w) - 1 + word_t'(cfg_q.fw)
                  - word_t'(cfg_q.iw) - word_t'(cfg_q.pad_left);
  assign bpad_raw = word_t'(cfg_q.n_patches_h) - 1 + word_t'(cfg_q.fh)
                  - word_t'(cfg_q.ih) - word_t'(cfg_q.pad_top);
  assign rpad = rpad_raw[`IM2COL_DATA_W-1] ? '0 : rpad_raw;  // clamp negative
  assign bpad = bpad_raw[`IM2COL_DATA_W-1] ? '0 : bpad_raw;

  assign sz1_c    = word_t'(cfg_q.n_patches_w) - z_left_q - z_right_q;
  assign patch_sz = word_t'(cfg_q.n_patches_h) * word_t'(cfg_q.n_patches_w);
  assign last_c   = (c_q == cfg_q.num_ch - 8'd1) && (kh_q == cfg_q.fh - 8'd1)
                  && (kw_q == cfg_q.fw - 8'd1);

  assign push_o   = (state_q == ST_PUSH) && !full_i;  // stall while the FIFO is full
  assign active_o = (state_q != ST_IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      c_q     <= '0;
      kh_q    <= '0;
      kw_q    <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_OFS;
            c_q     <= '0;
            kh_q    <= '0;
            kw_q    <= '0;
          end
        end
        ST_OFS:   state_q <= ST_COORD;
        ST_COORD: state_q <= ST_ZEROS;
        ST_ZEROS: state_q <= ST_XFER;
        ST_XFER:  state_q <= ST_PUSH;
        ST_PUSH: begin
          if (push_o) begin
            state_q <= last_c ? ST_IDLE : ST_OFS;
            // column innermost, then row, then channel
            if (kw_q == cfg_q.fw - 8'd1) begin
              kw_q <= '0;
              if (kh_q == cfg_q.fh - 8'd1) begin
                kh_q <= '0;
                c_q  <= c_q + 8'd1;
              end else begin
                kh_q <= kh_q + 8'd1;
              end
            end else begin
              kw_q <= kw_q + 8'd1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      cfg_q     <= cfg_i;
      out_ptr_q <= cfg_i.dst_ptr;
    end
    if (push_o) out_ptr_q <= out_ptr_q + patch_sz;  // next output slab
    case (state_q)
      ST_OFS: begin
        fw_min_q <= word_t'(cfg_q.fw) - 1 - word_t'(kw_q);
        fh_min_q <= word_t'(cfg_q.fh) - 1 - word_t'(kh_q);
      end
      ST_COORD: begin
        row_q <= word_t'(c_q) * word_t'(cfg_q.ih) + word_t'(kh_q) - word_t'(cfg_q.pad_top);
        col_q <= word_t'(kw_q) - word_t'(cfg_q.pad_left);
      end
      ST_ZEROS: begin
        z_left_q  <= (cfg_q.pad_left > kw_q) ? word_t'(cfg_q.pad_left - kw_q) : '0;
        z_top_q   <= (cfg_q.pad_top > kh_q) ? word_t'(cfg_q.pad_top - kh_q) : '0;
        z_right_q <= (rpad > fw_min_q) ? rpad - fw_min_q : '0;
        z_bot_q   <= (bpad > fh_min_q) ? bpad - fh_min_q : '0;
      end
      ST_XFER: begin
        sz1_q    <= sz1_c;
        sz2_q    <= word_t'(cfg_q.n_patches_h) - z_top_q - z_bot_q;
        in_ptr_q <= cfg_q.src_ptr + (row_q + z_top_q) * word_t'(cfg_q.iw) + col_q + z_left_q;
        in_inc_q <= word_t'(cfg_q.iw) - sz1_c + 1;  // jump back to the next row start
      end
      default: ;
    endcase
  end

  assign trans_o.input_ptr      = in_ptr_q;
  assign trans_o.output_ptr     = out_ptr_q;
  assign trans_o.in_inc_d2      = in_inc_q;
  assign trans_o.n_zeros_top    = z_top_q;
  assign trans_o.n_zeros_bottom = z_bot_q;
  assign trans_o.n_zeros_left   = z_left_q;
  assign trans_o.n_zeros_right  = z_right_q;
  assign trans_o.size_d1        = sz1_q;
  assign trans_o.size_d2        = sz2_q;
  assign trans_o.data_type      = cfg_q.data_type;

endmodule

`default_nettype wire

//--- source/im2col_pkg.sv
`default_nettype none
`include "im2col_defines.svh"

package im2col_pkg;

  // convolution setup, sampled on the start strobe
  typedef struct packed {
    logic [`IM2COL_DATA_W-1:0] src_ptr;
    logic [`IM2COL_DATA_W-1:0] dst_ptr;
    logic [15:0]               ih;
    logic [15:0]               iw;
    logic [15:0]               n_patches_h;
    logic [15:0]               n_patches_w;
    logic [7:0]                fh;
    logic [7:0]                fw;
    logic [7:0]                num_ch;
    logic [7:0]                pad_top;
    logic [7:0]                pad_left;
    logic [1:0]                data_type;
    logic                      irq_en;  // raise irq_o when the job ends
  } im2col_cfg_t;

  // one 2D DMA job, constant increments are left out
  typedef struct packed {
    logic [`IM2COL_DATA_W-1:0] input_ptr;
    logic [`IM2COL_DATA_W-1:0] output_ptr;
    logic [`IM2COL_DATA_W-1:0] in_inc_d2;
    logic [`IM2COL_DATA_W-1:0] n_zeros_top;
    logic [`IM2COL_DATA_W-1:0] n_zeros_bottom;
    logic [`IM2COL_DATA_W-1:0] n_zeros_left;
    logic [`IM2COL_DATA_W-1:0] n_zeros_right;
    logic [`IM2COL_DATA_W-1:0] size_d1;
    logic [`IM2COL_DATA_W-1:0] size_d2;
    logic [1:0]                data_type;
  } dma_trans_t;

  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [3:0]                be;
    logic [`IM2COL_ADDR_W-1:0] addr;
    logic [`IM2COL_DATA_W-1:0] wdata;
  } bus_req_t;

endpackage

`default_nettype wire

//--- source/im2col_spc.sv
`timescale 1ns/1ps
`default_nettype none
`include "im2col_defines.svh"

module im2col_spc (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          start_i,
  input  wire im2col_pkg::im2col_cfg_t cfg_i,
  output im2col_pkg::bus_req_t         bus_req_o,
  input  wire                          bus_gnt_i,
  input  wire [`IM2COL_NUM_CH-1:0]     dma_done_i,
  output logic                         done_o,
  output logic                         busy_o,
  output logic                         irq_o,
  input  wire                          irq_clr_i
);

  im2col_pkg::dma_trans_t  gen_trans, fifo_trans;
  logic                    gen_push, gen_active, start_ok;
  logic                    fifo_full, fifo_empty, fifo_pop;
  logic                    ch_free, ch_alloc, ld_idle;
  logic [`IM2COL_CH_W-1:0] ch_idx;
  logic                    busy_q, irq_en_q, irq_q;

  assign start_ok = start_i && !busy_q;  // a start during a job is ignored

  im2col_param_gen u_param_gen (
    .clk_i,
    .rst_ni,
    .start_i  (start_ok),
    .cfg_i,
    .full_i   (fifo_full),
    .push_o   (gen_push),
    .trans_o  (gen_trans),
    .active_o (gen_active)
  );

  im2col_fifo #(
    .payload_t (im2col_pkg::dma_trans_t),
    .depth     (`IM2COL_FIFO_DEPTH)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (gen_push),
    .data_i  (gen_trans),
    .pop_i   (fifo_pop),
    .data_o  (fifo_trans),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  im2col_ch_tracker u_ch_tracker (
    .clk_i,
    .rst_ni,
    .alloc_i    (ch_alloc),
    .dma_done_i,
    .free_o     (ch_free),
    .ch_o       (ch_idx)
  );

  im2col_dma_loader u_dma_loader (
    .clk_i,
    .rst_ni,
    .empty_i   (fifo_empty),
    .trans_i   (fifo_trans),
    .pop_o     (fifo_pop),
    .free_i    (ch_free),
    .ch_i      (ch_idx),
    .alloc_o   (ch_alloc),
    .bus_req_o,
    .bus_gnt_i,
    .idle_o    (ld_idle)
  );

  // all jobs generated, queued and written out
  assign done_o = busy_q && !gen_active && fifo_empty && ld_idle;
  assign busy_o = busy_q;
  assign irq_o  = irq_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      irq_en_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (start_ok) begin
        busy_q   <= 1'b1;
        irq_en_q <= cfg_i.irq_en;
      end else if (done_o) begin
        busy_q <= 1'b0;
      end
      if (done_o && irq_en_q) irq_q <= 1'b1;  // sticky until cleared
      else if (irq_clr_i) irq_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_im2col_spc.sv
`timescale 1ns/1ps
`default_nettype none
`include "im2col_defines.svh"

module tb_im2col_spc;

  localparam int NUM_CH  = `IM2COL_NUM_CH;
  localparam int CH      = 2;  // input channels of the test convolution
  localparam int FH      = 3;
  localparam int FW      = 3;
  localparam int IH      = 5;
  localparam int IW      = 5;
  localparam int PAD_T   = 1;
  localparam int PAD_L   = 1;
  localparam int NPH     = 5;
  localparam int NPW     = 5;
  localparam int DTYPE   = 2;
  localparam int TRANS_N = CH * FH * FW;
  localparam int RUNS    = 2;
  localparam int WD_CYCLES = RUNS * 14 * TRANS_N * 20 + 500;
  localparam logic [31:0] SRC_PTR = 32'h0000_1000;
  localparam logic [31:0] DST_PTR = 32'h0002_0000;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     start_i;
  im2col_pkg::im2col_cfg_t  cfg_i;
  im2col_pkg::bus_req_t     bus_req_o;
  logic                     bus_gnt_i = 1'b0;
  logic [NUM_CH-1:0]        dma_done_i = '0;
  logic                     done_o, busy_o, irq_o;
  logic                     irq_clr_i;

  integer            seed = 32'ha75c_8df5;
  logic [NUM_CH-1:0] tb_busy = '0;          // channels started and not yet done
  int                d1_count [NUM_CH] = '{default: 0};
  int                d1_seen [NUM_CH] = '{default: 0};
  int                done_wait [NUM_CH] = '{default: 0};
  int                w_idx = 0;             // register index inside a sequence
  int                seq_total = 0;
  int                seq_base = 0;          // seq_total at the start of a job
  int                done_pulses = 0;
  logic              irq_low_chk = 1'b0;
  logic [`IM2COL_CH_W-1:0] seq_ch = '0;

  im2col_spc u_dut (
    .clk_i, .rst_ni, .start_i, .cfg_i, .bus_req_o, .bus_gnt_i,
    .dma_done_i, .done_o, .busy_o, .irq_o, .irq_clr_i
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    stop_failed();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    stop_failed();
  endtask

  // register offset of each of the fourteen writes
  function automatic logic [31:0] expected_offset(input int idx);
    case (idx)
      0:       return `IM2COL_OFS_DIM;
      1:       return `IM2COL_OFS_DATA_TYPE;
      2:       return `IM2COL_OFS_TOP_PAD;
      3:       return `IM2COL_OFS_BOTTOM_PAD;
      4:       return `IM2COL_OFS_LEFT_PAD;
      5:       return `IM2COL_OFS_RIGHT_PAD;
      6:       return `IM2COL_OFS_SRC_PTR;
      7:       return `IM2COL_OFS_DST_PTR;
      8:       return `IM2COL_OFS_SRC_INC_D1;
      9:       return `IM2COL_OFS_SRC_INC_D2;
      10:      return `IM2COL_OFS_DST_INC_D1;
      11:      return `IM2COL_OFS_DST_INC_D2;
      12:      return `IM2COL_OFS_SIZE_D2;
      default: return `IM2COL_OFS_SIZE_D1;
    endcase
  endfunction

  // reference model of write idx for transaction t of a job
  function automatic logic [31:0] expected_word(input int t, input int idx);
    int c, kh, kw, rpad, bpad, top, bottom, left, right, sz1, sz2;
    logic [31:0] in_ptr, out_ptr;
    c  = t / (FH * FW);
    kh = (t / FW) % FH;
    kw = t % FW;
    rpad = NPW - 1 + FW - IW - PAD_L;
    bpad = NPH - 1 + FH - IH - PAD_T;
    if (rpad < 0) rpad = 0;
    if (bpad < 0) bpad = 0;
    left   = (PAD_L - kw > 0) ? PAD_L - kw : 0;
    top    = (PAD_T - kh > 0) ? PAD_T - kh : 0;
    right  = (rpad - (FW - 1 - kw) > 0) ? rpad - (FW - 1 - kw) : 0;
    bottom = (bpad - (FH - 1 - kh) > 0) ? bpad - (FH - 1 - kh) : 0;
    sz1 = NPW - left - right;
    sz2 = NPH - top - bottom;
    in_ptr  = SRC_PTR + 32'((c * IH + kh - PAD_T + top) * IW + kw - PAD_L + left);
    out_ptr = DST_PTR + 32'(t * NPH * NPW);
    case (idx)
      1:       return 32'(DTYPE);
      2:       return 32'(top);
      3:       return 32'(bottom);
      4:       return 32'(left);
      5:       return 32'(right);
      6:       return in_ptr;
      7:       return out_ptr;
      9:       return 32'(IW - sz1 + 1);
      12:      return 32'(sz2);
      13:      return 32'(sz1);
      default: return 32'h1;  // dimensionality and the constant increments
    endcase
  endfunction

  function automatic im2col_pkg::im2col_cfg_t make_cfg(input logic irq_en);
    im2col_pkg::im2col_cfg_t cfg;
    cfg             = '0;
    cfg.src_ptr     = SRC_PTR;
    cfg.dst_ptr     = DST_PTR;
    cfg.ih          = 16'(IH);
    cfg.iw          = 16'(IW);
    cfg.n_patches_h = 16'(NPH);
    cfg.n_patches_w = 16'(NPW);
    cfg.fh          = 8'(FH);
    cfg.fw          = 8'(FW);
    cfg.num_ch      = 8'(CH);
    cfg.pad_top     = 8'(PAD_T);
    cfg.pad_left    = 8'(PAD_L);
    cfg.data_type   = 2'(DTYPE);
    cfg.irq_en      = irq_en;
    return cfg;
  endfunction

  // grant and DMA completion driven on the falling edge
  always @(negedge clk_i) begin
    bus_gnt_i = (($random(seed) & 3) != 0);  // about three grants in four cycles
    for (int i = 0; i < NUM_CH; i++) begin
      dma_done_i[i] = 1'b0;
      if (d1_count[i] != d1_seen[i]) begin
        d1_seen[i]   = d1_count[i];
        done_wait[i] = 8 + ($random(seed) & 31);
      end else if (done_wait[i] > 0) begin
        done_wait[i]--;
        if (done_wait[i] == 0) dma_done_i[i] = 1'b1;
      end
    end
  end

  // bus monitor and checks
  always @(posedge clk_i) begin
    logic [31:0] rel, ch_full, exp_addr, exp_data;
    if (rst_ni) begin
      if (tb_busy == '1)
        assert (!bus_req_o.req) else report_failure("bus request while both channels busy");
      if (irq_low_chk) assert (!irq_o) else report_mismatch("irq_o", 32'(irq_o), 32'h0);
      if (done_o) begin
        assert (busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'h1);
        assert (!bus_req_o.req) else report_failure("done_o while a write is pending");
        assert (w_idx == 0) else report_failure("done_o in the middle of a sequence");
        assert (seq_total - seq_base == TRANS_N)
          else report_mismatch("sequence count", 32'(seq_total - seq_base), 32'(TRANS_N));
        done_pulses++;
      end
      for (int i = 0; i < NUM_CH; i++) begin
        if (dma_done_i[i]) tb_busy[i] = 1'b0;
      end
      if (bus_req_o.req && bus_gnt_i) begin
        rel     = bus_req_o.addr - `IM2COL_DMA_BASE;
        ch_full = rel / `IM2COL_DMA_CH_SIZE;
        assert (bus_req_o.we) else report_mismatch("bus_req_o.we", 32'(bus_req_o.we), 32'h1);
        assert (bus_req_o.be == 4'hf)
          else report_mismatch("bus_req_o.be", 32'(bus_req_o.be), 32'hf);
        if (w_idx == 0) begin
          assert (ch_full < NUM_CH) else report_failure("write outside the DMA channels");
          seq_ch = ch_full[`IM2COL_CH_W-1:0];
          assert (!tb_busy[seq_ch]) else report_failure("channel restarted before its done");
          assert (seq_total - seq_base < TRANS_N) else report_failure("too many sequences");
        end
        exp_addr = `IM2COL_DMA_BASE + 32'(seq_ch) * `IM2COL_DMA_CH_SIZE + expected_offset(w_idx);
        exp_data = expected_word(seq_total - seq_base, w_idx);
        assert (bus_req_o.addr == exp_addr)
          else report_mismatch("bus_req_o.addr", bus_req_o.addr, exp_addr);
        assert (bus_req_o.wdata == exp_data)
          else report_mismatch("bus_req_o.wdata", bus_req_o.wdata, exp_data);
        if (w_idx == 13) begin  // size d1 starts the channel
          tb_busy[seq_ch] = 1'b1;
          d1_count[seq_ch]++;
          seq_total++;
          w_idx = 0;
        end else begin
          w_idx++;
        end
      end
    end
  end

  task automatic run_job(input logic irq_en, input logic poke_start);
    im2col_pkg::im2col_cfg_t cfg;
    int pulses_before;
    cfg           = make_cfg(irq_en);
    pulses_before = done_pulses;
    seq_base      = seq_total;
    irq_low_chk   = 1'b1;
    @(negedge clk_i);
    cfg_i   = cfg;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    assert (busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'h1);
    if (poke_start) begin
      // the generator is idle once the last transaction is on the bus
      while (!(seq_total - seq_base == TRANS_N - 1 && w_idx > 0)) @(negedge clk_i);
      assert (busy_o) else report_failure("job ended before the second start");
      cfg_i.src_ptr = 32'hdead_0000;  // a restarted job would use this pointer
      cfg_i.irq_en  = !irq_en;
      start_i       = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      cfg_i   = cfg;
    end
    while (done_pulses == pulses_before) @(negedge clk_i);
    assert (!busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'h0);
    assert (irq_o == irq_en) else report_mismatch("irq_o", 32'(irq_o), 32'(irq_en));
    irq_low_chk = !irq_en;
    repeat (8) @(negedge clk_i);
    assert (done_pulses == pulses_before + 1)
      else report_mismatch("done_o pulses", 32'(done_pulses - pulses_before), 32'h1);
    if (irq_en) begin
      assert (irq_o) else report_mismatch("irq_o", 32'(irq_o), 32'h1);
      irq_clr_i = 1'b1;
      @(negedge clk_i);
      irq_clr_i = 1'b0;
      assert (!irq_o) else report_mismatch("irq_o", 32'(irq_o), 32'h0);
    end
  endtask

  initial begin
    rst_ni    = 1'b0;
    start_i   = 1'b0;
    cfg_i     = '0;
    irq_clr_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    assert (!bus_req_o.req) else report_mismatch("bus_req_o.req", 32'(bus_req_o.req), 32'h0);
    assert (!done_o) else report_mismatch("done_o", 32'(done_o), 32'h0);
    assert (!busy_o) else report_mismatch("busy_o", 32'(busy_o), 32'h0);
    assert (!irq_o) else report_mismatch("irq_o", 32'(irq_o), 32'h0);
    rst_ni = 1'b1;
    repeat (3) @(negedge clk_i);
    run_job(1'b1, 1'b1);  // irq on, extra start while busy
    run_job(1'b0, 1'b0);
    if (seq_total != RUNS * TRANS_N) begin
      report_mismatch("total sequences", 32'(seq_total), 32'(RUNS * TRANS_N));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    report_failure("watchdog timeout, the jobs did not finish in time");
  end

endmodule

`default_nettype wire
